//--- dataSram.sv
`timescale 1ns/100ps

module dataSram import lsuPkg::*; (
    input  logic    clk,
    input  logic    memEn,
    input  logic    memWe,
    input  MemAddr  memAddr,
    input  MemWord  memWData,
    input  ByteMask memMask,
    output MemWord  rData
);
    localparam int WORDS = 256;
    localparam int IDX_BITS = $clog2(WORDS);

    MemWord mem [WORDS];
    logic [IDX_BITS-1:0] memIdx;
    logic [IDX_BITS-1:0] readIdx;

    assign memIdx = memAddr[IDX_BITS-1:0];

    always_ff @(posedge clk) begin
        if (memEn && memWe) begin
            for (int b = 0; b < 4; b++) begin
                if (memMask[b])
                    mem[memIdx][8*b +: 8] <= memWData[8*b +: 8];
            end
        end
        if (memEn && !memWe)
            readIdx <= memIdx;
        // Array read one cycle after the address latch
        rData <= mem[readIdx];
    end

endmodule

//--- loadResult.sv
`timescale 1ns/100ps

module loadResult import lsuPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    loadIssued,
    input  SqNum    loadSqN,
    input  MemWord  fwdData,
    input  ByteMask fwdMask,
    input  MemWord  rData,
    input  logic    branchTaken,
    input  SqNum    branchSqN,
    output logic    resultValid,
    output SqNum    resultSqN,
    output MemWord  resultData
);
    logic s1Valid;
    logic s2Valid;
    SqNum s1SqN;
    SqNum s2SqN;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
        end else begin
            s1Valid <= loadIssued && !(branchTaken && isOlder(branchSqN, loadSqN));
            s2Valid <= s1Valid && !(branchTaken && isOlder(branchSqN, s1SqN));
        end
    end

    always_ff @(posedge clk) begin
        s1SqN <= loadSqN;
        s2SqN <= s1SqN;
    end

    assign resultValid = s2Valid;
    assign resultSqN = s2SqN;

    // Forwarded store bytes override the SRAM word
    always_comb begin
        for (int b = 0; b < 4; b++)
            resultData[8*b +: 8] = fwdMask[b] ? fwdData[8*b +: 8] : rData[8*b +: 8];
    end

endmodule

//--- lsuDefs_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Store queue slots, must be a power of two
`define SQ_ENTRIES 8
// Issue buffer slots and the sender's starting credits
`define ISSUE_DEPTH 4
`define SQN_BITS 6

`endif

//--- lsuPkg.sv
`include "lsuDefs_defs.svh"

package lsuPkg;

    // Instruction order and store slot order share this width
    typedef logic [`SQN_BITS-1:0] SqNum;

    // Word address, byte offset already dropped
    typedef logic [29:0] MemAddr;
    typedef logic [31:0] MemWord;
    typedef logic [3:0] ByteMask;

    // True when a comes before b, modulo the sequence number range
    function automatic logic isOlder(SqNum a, SqNum b);
        SqNum diff;
        diff = a - b;
        return diff[`SQN_BITS-1];
    endfunction

endpackage

//--- lsuTb.sv
`timescale 1ns/100ps
`include "lsuDefs_defs.svh"

module lsuTb import lsuPkg::*; ();
    localparam int NUM_OPS = 160;
    localparam int WATCH_CYCLES = 60 * NUM_OPS + 200;

    logic clk;
    logic rst;
    logic opValid;
    logic opIsLoad;
    MemAddr opAddr;
    MemWord opData;
    ByteMask opMask;
    SqNum opSqN;
    SqNum opStoreSqN;
    SqNum curSqN;
    logic branchTaken;
    SqNum branchSqN;
    SqNum branchStoreSqN;
    logic creditReturn;
    logic resultValid;
    SqNum resultSqN;
    MemWord resultData;

    logic [31:0] lfsr = 32'h74064c51;
    int credits;
    SqNum nextSqN;
    SqNum nextStore;
    SqNum committed;
    // storeSqN to use after each op when recovering from a branch
    SqNum storeAfter [64];
    MemWord memModel [4];
    SqNum lsSqN [$];
    int lsIdx [$];
    MemWord lsData [$];
    ByteMask lsMask [$];
    SqNum expSqN [$];
    MemWord expData [$];

    lsuTop dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic nextBit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'hA3000000;
        return b;
    endfunction

    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], nextBit()};
        return v;
    endfunction

    // Four words that differ in the SRAM index bits
    function automatic MemAddr addrOf(int ai);
        case (ai)
            0: return 30'h10;
            1: return 30'h23;
            2: return 30'h1A5;
            default: return 30'h3FF;
        endcase
    endfunction

    // Memory word with every live older store merged in oldest first
    function automatic MemWord expectedLoad(int ai, SqNum s);
        MemWord w;
        w = memModel[ai];
        for (int i = 0; i < lsSqN.size(); i++) begin
            if (lsIdx[i] == ai && isOlder(lsSqN[i], s)) begin
                for (int b = 0; b < 4; b++) begin
                    if (lsMask[i][b])
                        w[8*b +: 8] = lsData[i][8*b +: 8];
                end
            end
        end
        return w;
    endfunction

    task automatic checkWord(string name, MemWord got, MemWord exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic checkSqNum(string name, SqNum got, SqNum exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic failPlain(string what);
        $display("%s at %0t", what, $time);
        $display("Errors found");
        $fatal(1);
    endtask

    // Count credits at the falling edge and wait for the next rising edge
    task automatic nextEdge();
        @(negedge clk);
        if (creditReturn)
            credits++;
        if (credits > `ISSUE_DEPTH)
            failPlain("More credits returned than operations sent");
        @(posedge clk);
        opValid <= 1'b0;
        branchTaken <= 1'b0;
    endtask

    task automatic commitAll();
        committed = nextSqN;
        curSqN <= nextSqN;
        while (lsSqN.size() > 0 && isOlder(lsSqN[0], committed)) begin
            for (int b = 0; b < 4; b++) begin
                if (lsMask[0][b])
                    memModel[lsIdx[0]][8*b +: 8] = lsData[0][8*b +: 8];
            end
            void'(lsSqN.pop_front());
            void'(lsIdx.pop_front());
            void'(lsData.pop_front());
            void'(lsMask.pop_front());
        end
    endtask

    task automatic sendOp(logic isLoad, int ai, MemWord data, ByteMask mask);
        int stall;
        stall = 0;
        nextEdge();
        while (credits == 0 || SqNum'(nextSqN - committed) >= 28) begin
            stall++;
            // Queue full with commit held back so commit moves on
            if (stall > 30 || SqNum'(nextSqN - committed) >= 28)
                commitAll();
            nextEdge();
        end
        opValid <= 1'b1;
        opIsLoad <= isLoad;
        opAddr <= addrOf(ai);
        opData <= data;
        opMask <= mask;
        opSqN <= nextSqN;
        opStoreSqN <= nextStore;
        credits--;
        if (isLoad) begin
            expSqN.push_back(nextSqN);
            expData.push_back(expectedLoad(ai, nextSqN));
        end else begin
            lsSqN.push_back(nextSqN);
            lsIdx.push_back(ai);
            lsData.push_back(data);
            lsMask.push_back(mask);
            nextStore++;
        end
        storeAfter[nextSqN] = nextStore;
        nextSqN++;
    endtask

    task automatic takeBranch();
        int span;
        SqNum b;
        span = int'(SqNum'(nextSqN - committed));
        if (span == 0)
            return;
        b = committed + SqNum'(randBits(5) % span);
        nextEdge();
        branchTaken <= 1'b1;
        branchSqN <= b;
        branchStoreSqN <= storeAfter[b] - 1'b1;
        while (lsSqN.size() > 0 && isOlder(b, lsSqN[$])) begin
            void'(lsSqN.pop_back());
            void'(lsIdx.pop_back());
            void'(lsData.pop_back());
            void'(lsMask.pop_back());
        end
        nextSqN = b + 1'b1;
        nextStore = storeAfter[b];
    endtask

    // Compare results and drop loads killed by a branch in the same cycle
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && resultValid) begin
                if (expSqN.size() == 0)
                    failPlain("Result appeared with no load pending");
                checkSqNum("resultSqN", resultSqN, expSqN.pop_front());
                checkWord("resultData", resultData, expData.pop_front());
            end
            if (!rst && branchTaken) begin
                for (int i = expSqN.size() - 1; i >= 0; i--) begin
                    if (isOlder(branchSqN, expSqN[i])) begin
                        expSqN.delete(i);
                        expData.delete(i);
                    end
                end
            end
        end
    end

    initial begin
        #(WATCH_CYCLES * 20);
        $display("Results stopped arriving before the test finished");
        $display("Errors found");
        $fatal(1);
    end

    initial begin
        logic hold;
        ByteMask m;
        rst = 1'b1;
        opValid = 1'b0;
        opIsLoad = 1'b0;
        opAddr = '0;
        opData = '0;
        opMask = '0;
        opSqN = '0;
        opStoreSqN = '0;
        curSqN = '0;
        branchTaken = 1'b0;
        branchSqN = '0;
        branchStoreSqN = '0;
        credits = `ISSUE_DEPTH;
        nextSqN = '0;
        nextStore = '0;
        committed = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            if (creditReturn || resultValid)
                failPlain("Output active after reset with no operation sent");
        end
        @(posedge clk);
        for (int ai = 0; ai < 4; ai++)
            sendOp(1'b0, ai, randBits(32), 4'hF);
        commitAll();
        for (int op = 4; op < NUM_OPS; op++) begin
            hold = (op >= 60 && op < 100);
            m = ByteMask'(randBits(4));
            if (m == '0)
                m = 4'hF;
            sendOp(nextBit(), int'(randBits(2)), randBits(32), m);
            if (!hold && randBits(2) == 0)
                commitAll();
            if (!hold && randBits(3) == 0)
                takeBranch();
        end
        nextEdge();
        commitAll();
        while (expSqN.size() > 0 || credits != `ISSUE_DEPTH)
            nextEdge();
        repeat (4) nextEdge();
        $display("No errors");
        $finish;
    end

endmodule

//--- lsuTop.sv
`timescale 1ns/100ps

module lsuTop import lsuPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    opValid,
    input  logic    opIsLoad,
    input  MemAddr  opAddr,
    input  MemWord  opData,
    input  ByteMask opMask,
    input  SqNum    opSqN,
    input  SqNum    opStoreSqN,
    input  SqNum    curSqN,
    input  logic    branchTaken,
    input  SqNum    branchSqN,
    input  SqNum    branchStoreSqN,
    output logic    creditReturn,
    output logic    resultValid,
    output SqNum    resultSqN,
    output MemWord  resultData
);
    logic    issueValid;
    logic    issueIsLoad;
    MemAddr  issueAddr;
    MemWord  issueData;
    ByteMask issueMask;
    SqNum    issueSqN;
    SqNum    issueStoreSqN;
    SqNum    maxStoreSqN;

    logic    memEn;
    logic    memWe;
    MemAddr  memAddr;
    MemWord  memWData;
    ByteMask memMask;
    MemWord  rData;

    MemWord  fwdData;
    ByteMask fwdMask;
    logic    loadIssued;
    SqNum    loadSqN;

    opIssue issue (
        .clk(clk), .rst(rst),
        .opValid(opValid), .opIsLoad(opIsLoad), .opAddr(opAddr), .opData(opData),
        .opMask(opMask), .opSqN(opSqN), .opStoreSqN(opStoreSqN),
        .branchTaken(branchTaken), .branchSqN(branchSqN), .maxStoreSqN(maxStoreSqN),
        .creditReturn(creditReturn), .issueValid(issueValid), .issueIsLoad(issueIsLoad),
        .issueAddr(issueAddr), .issueData(issueData), .issueMask(issueMask),
        .issueSqN(issueSqN), .issueStoreSqN(issueStoreSqN)
    );

    storeQueue sq (
        .clk(clk), .rst(rst),
        .issueValid(issueValid), .issueIsLoad(issueIsLoad), .issueAddr(issueAddr),
        .issueData(issueData), .issueMask(issueMask), .issueSqN(issueSqN),
        .issueStoreSqN(issueStoreSqN), .curSqN(curSqN),
        .branchTaken(branchTaken), .branchSqN(branchSqN), .branchStoreSqN(branchStoreSqN),
        .maxStoreSqN(maxStoreSqN), .memEn(memEn), .memWe(memWe), .memAddr(memAddr),
        .memWData(memWData), .memMask(memMask), .fwdData(fwdData), .fwdMask(fwdMask),
        .loadIssued(loadIssued), .loadSqN(loadSqN)
    );

    dataSram sram (
        .clk(clk), .memEn(memEn), .memWe(memWe), .memAddr(memAddr),
        .memWData(memWData), .memMask(memMask), .rData(rData)
    );

    loadResult result (
        .clk(clk), .rst(rst),
        .loadIssued(loadIssued), .loadSqN(loadSqN), .fwdData(fwdData), .fwdMask(fwdMask),
        .rData(rData), .branchTaken(branchTaken), .branchSqN(branchSqN),
        .resultValid(resultValid), .resultSqN(resultSqN), .resultData(resultData)
    );

endmodule

//--- opIssue.sv
`timescale 1ns/100ps
`include "lsuDefs_defs.svh"

module opIssue import lsuPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    opValid,
    input  logic    opIsLoad,
    input  MemAddr  opAddr,
    input  MemWord  opData,
    input  ByteMask opMask,
    input  SqNum    opSqN,
    input  SqNum    opStoreSqN,
    input  logic    branchTaken,
    input  SqNum    branchSqN,
    input  SqNum    maxStoreSqN,
    output logic    creditReturn,
    output logic    issueValid,
    output logic    issueIsLoad,
    output MemAddr  issueAddr,
    output MemWord  issueData,
    output ByteMask issueMask,
    output SqNum    issueSqN,
    output SqNum    issueStoreSqN
);
    localparam int PTR_BITS = $clog2(`ISSUE_DEPTH);
    localparam int CNT_BITS = $clog2(`ISSUE_DEPTH + 1);

    logic    bufIsLoad   [`ISSUE_DEPTH];
    MemAddr  bufAddr     [`ISSUE_DEPTH];
    MemWord  bufData     [`ISSUE_DEPTH];
    ByteMask bufMask     [`ISSUE_DEPTH];
    SqNum    bufSqN      [`ISSUE_DEPTH];
    SqNum    bufStoreSqN [`ISSUE_DEPTH];

    logic [PTR_BITS-1:0] headPtr;
    logic [PTR_BITS-1:0] pushPtr;
    logic [CNT_BITS-1:0] count;
    logic [CNT_BITS-1:0] killCount;
    // Credits owed to the sender, returned one per cycle
    logic [CNT_BITS-1:0] pending;
    logic headKill;
    logic storeStall;
    logic pushKeep;
    logic pushDrop;

    assign issueIsLoad = bufIsLoad[headPtr];
    assign issueAddr = bufAddr[headPtr];
    assign issueData = bufData[headPtr];
    assign issueMask = bufMask[headPtr];
    assign issueSqN = bufSqN[headPtr];
    assign issueStoreSqN = bufStoreSqN[headPtr];

    assign headKill = branchTaken && isOlder(branchSqN, bufSqN[headPtr]);
    // Store waits until its queue slot exists
    assign storeStall = !bufIsLoad[headPtr] && isOlder(maxStoreSqN, bufStoreSqN[headPtr]);
    assign issueValid = (count != '0) && !storeStall && !headKill;

    assign pushKeep = opValid && !(branchTaken && isOlder(branchSqN, opSqN));
    assign pushDrop = opValid && !pushKeep;
    assign creditReturn = (pending != '0);

    // Younger ops always sit at the tail, so a squash just shortens the buffer
    always_comb begin
        killCount = '0;
        if (branchTaken) begin
            for (int i = 0; i < `ISSUE_DEPTH; i++) begin
                if (i < int'(count) && isOlder(branchSqN, bufSqN[headPtr + PTR_BITS'(i)]))
                    killCount = killCount + 1'b1;
            end
        end
        pushPtr = headPtr + PTR_BITS'(count - killCount);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            count <= '0;
            pending <= '0;
        end else begin
            headPtr <= headPtr + PTR_BITS'(issueValid);
            count <= count - CNT_BITS'(issueValid) - killCount + CNT_BITS'(pushKeep);
            pending <= pending - CNT_BITS'(creditReturn) + CNT_BITS'(issueValid)
                       + killCount + CNT_BITS'(pushDrop);
        end
    end

    always_ff @(posedge clk) begin
        if (pushKeep) begin
            bufIsLoad[pushPtr] <= opIsLoad;
            bufAddr[pushPtr] <= opAddr;
            bufData[pushPtr] <= opData;
            bufMask[pushPtr] <= opMask;
            bufSqN[pushPtr] <= opSqN;
            bufStoreSqN[pushPtr] <= opStoreSqN;
        end
    end

    // Sender credit count must keep the buffer from overflowing
    assert property (@(posedge clk) disable iff (rst)
        opValid |-> count < CNT_BITS'(`ISSUE_DEPTH))
        else $error("opIssue: op sent into a full buffer");

endmodule

//--- run.sh
#!/bin/bash
# Build and run with Verilator, fail if the log reports errors
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module lsuTb -o lsuSim \
    && ./obj_dir/lsuSim > sim.log 2>&1
cat sim.log 2>/dev/null
test -f sim.log && ! grep -q "Errors found" sim.log && grep -q "No errors" sim.log \
    && echo "PASS" || { echo "FAIL"; exit 1; }

//--- storeQueue.sv
`timescale 1ns/100ps
`include "lsuDefs_defs.svh"

module storeQueue import lsuPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    issueValid,
    input  logic    issueIsLoad,
    input  MemAddr  issueAddr,
    input  MemWord  issueData,
    input  ByteMask issueMask,
    input  SqNum    issueSqN,
    input  SqNum    issueStoreSqN,
    input  SqNum    curSqN,
    input  logic    branchTaken,
    input  SqNum    branchSqN,
    // storeSqN of the last store older than the branch
    input  SqNum    branchStoreSqN,
    output SqNum    maxStoreSqN,
    output logic    memEn,
    output logic    memWe,
    output MemAddr  memAddr,
    output MemWord  memWData,
    output ByteMask memMask,
    output MemWord  fwdData,
    output ByteMask fwdMask,
    output logic    loadIssued,
    output SqNum    loadSqN
);
    localparam int IDX_BITS = $clog2(`SQ_ENTRIES);

    logic    entryValid [`SQ_ENTRIES];
    SqNum    entrySqN   [`SQ_ENTRIES];
    MemAddr  entryAddr  [`SQ_ENTRIES];
    MemWord  entryData  [`SQ_ENTRIES];
    ByteMask entryMask  [`SQ_ENTRIES];

    // storeSqN of the oldest live store
    SqNum baseIndex;
    logic [IDX_BITS-1:0] headSlot;
    logic [IDX_BITS-1:0] storeSlot;
    logic loadReq;
    logic storeIn;
    logic drain;

    // Lookup stage runs alongside the SRAM array read
    MemAddr  lkAddr;
    SqNum    lkSqN;
    MemWord  scanData;
    ByteMask scanMask;

    assign headSlot = baseIndex[IDX_BITS-1:0];
    assign storeSlot = issueStoreSqN[IDX_BITS-1:0];
    assign maxStoreSqN = baseIndex + SqNum'(`SQ_ENTRIES - 1);

    assign loadReq = issueValid && issueIsLoad;
    assign storeIn = issueValid && !issueIsLoad;
    // Loads take the port before a committed store
    assign drain = !loadReq && entryValid[headSlot] && isOlder(entrySqN[headSlot], curSqN);

    assign memEn = loadReq || drain;
    assign memWe = drain;
    assign memAddr = loadReq ? issueAddr : entryAddr[headSlot];
    assign memWData = entryData[headSlot];
    assign memMask = entryMask[headSlot];

    assign loadIssued = loadReq;
    assign loadSqN = issueSqN;

    always_comb begin
        logic [IDX_BITS-1:0] slot;
        scanData = '0;
        scanMask = '0;
        // Walk oldest to newest so the newest store wins each byte
        for (int k = 0; k < `SQ_ENTRIES; k++) begin
            slot = headSlot + IDX_BITS'(k);
            if (entryValid[slot] && entryAddr[slot] == lkAddr
                    && isOlder(entrySqN[slot], lkSqN)) begin
                for (int b = 0; b < 4; b++) begin
                    if (entryMask[slot][b])
                        scanData[8*b +: 8] = entryData[slot][8*b +: 8];
                end
                scanMask = scanMask | entryMask[slot];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            baseIndex <= '0;
            for (int i = 0; i < `SQ_ENTRIES; i++)
                entryValid[i] <= 1'b0;
        end else begin
            if (branchTaken) begin
                for (int i = 0; i < `SQ_ENTRIES; i++) begin
                    if (isOlder(branchSqN, entrySqN[i]))
                        entryValid[i] <= 1'b0;
                end
            end
            // Entry leaves at the same edge the SRAM takes its bytes
            if (drain) begin
                entryValid[headSlot] <= 1'b0;
                baseIndex <= baseIndex + 1'b1;
            end
            if (storeIn)
                entryValid[storeSlot] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (storeIn) begin
            entrySqN[storeSlot] <= issueSqN;
            entryAddr[storeSlot] <= issueAddr;
            entryData[storeSlot] <= issueData;
            entryMask[storeSlot] <= issueMask;
        end
        lkAddr <= issueAddr;
        lkSqN <= issueSqN;
        fwdData <= scanData;
        fwdMask <= scanMask;
    end

    // Issue holds stores back until their slot has drained
    assert property (@(posedge clk) disable iff (rst) storeIn |-> !entryValid[storeSlot])
        else $error("storeQueue: store enqueued into a live slot");

    // Commit never passes an unresolved branch
    assert property (@(posedge clk) disable iff (rst)
        branchTaken |-> !isOlder(branchStoreSqN + 1'b1, baseIndex))
        else $error("storeQueue: branch squashes an already drained store");

endmodule

//--- verilog.f
+incdir+.
lsuPkg.sv
opIssue.sv
storeQueue.sv
dataSram.sv
loadResult.sv
lsuTop.sv
lsuTb.sv
